//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pipeline_cpu_top
FILELIST  ?= pipeline_cpu_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- pipeline_cpu_top.f
+incdir+source
+incdir+test
source/rv_core_pkg.sv
source/pipe_reg.sv
source/gpr.sv
source/decoder.sv
source/execute.sv
source/pc_ctrl.sv
source/pipeline_cpu_top.sv
test/tb_pipeline_cpu_top.sv

//--- source/decoder.sv
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module decoder (
    input  rv_core_pkg::if_id_t        if_id,
    output logic [`GPR_ADDR_WIDTH-1:0] rd_addr_0,
    output logic [`GPR_ADDR_WIDTH-1:0] rd_addr_1,
    input  logic [`XLEN-1:0]           rd_data_0,
    input  logic [`XLEN-1:0]           rd_data_1,
    output rv_core_pkg::id_ex_t        id_ex
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`XLEN-1:0]    imm_i;
    logic [`XLEN-1:0]    imm_s;
    logic [`XLEN-1:0]    imm_b;
    logic                use_rs1;
    logic                use_rs2;
    rv_core_pkg::id_ex_t dec;

    assign opcode = if_id.insn[6:0];
    assign funct3 = if_id.insn[14:12];
    assign funct7 = if_id.insn[31:25];

    assign imm_i = {{20{if_id.insn[31]}}, if_id.insn[31:20]};
    assign imm_s = {{20{if_id.insn[31]}}, if_id.insn[31:25], if_id.insn[11:7]};
    assign imm_b = {{19{if_id.insn[31]}}, if_id.insn[31], if_id.insn[7],
                    if_id.insn[30:25], if_id.insn[11:8], 1'b0};

    always_comb begin
        dec        = '0;
        dec.pc     = if_id.pc;
        dec.alu_op = rv_core_pkg::ALU_ADD;
        dec.wb_sel = rv_core_pkg::WB_ALU;
        use_rs1    = 1'b0;
        use_rs2    = 1'b0;
        case (opcode)
            `OPC_OP: begin
                if (funct7 == 7'b0 || (funct3 == `F3_ADD_SUB && funct7 == `F7_SUB)) begin
                    use_rs1    = 1'b1;
                    use_rs2    = 1'b1;
                    dec.reg_we = 1'b1;
                    case (funct3)
                        `F3_ADD_SUB: dec.alu_op = (funct7 == `F7_SUB) ? rv_core_pkg::ALU_SUB
                                                                      : rv_core_pkg::ALU_ADD;
                        `F3_SLT: dec.alu_op = rv_core_pkg::ALU_SLT;
                        `F3_XOR: dec.alu_op = rv_core_pkg::ALU_XOR;
                        `F3_OR:  dec.alu_op = rv_core_pkg::ALU_OR;
                        `F3_AND: dec.alu_op = rv_core_pkg::ALU_AND;
                        default: begin
                            // shifts and sltu are not supported
                            use_rs1    = 1'b0;
                            use_rs2    = 1'b0;
                            dec.reg_we = 1'b0;
                        end
                    endcase
                end
            end
            `OPC_OP_IMM: begin
                // addi only
                if (funct3 == `F3_ADD_SUB) begin
                    use_rs1     = 1'b1;
                    dec.use_imm = 1'b1;
                    dec.imm     = imm_i;
                    dec.reg_we  = 1'b1;
                end
            end
            `OPC_LOAD: begin
                if (funct3 == `F3_LW_SW) begin
                    use_rs1     = 1'b1;
                    dec.use_imm = 1'b1;
                    dec.imm     = imm_i;
                    dec.mem_re  = 1'b1;
                    dec.reg_we  = 1'b1;
                    dec.wb_sel  = rv_core_pkg::WB_LOAD;
                end
            end
            `OPC_STORE: begin
                if (funct3 == `F3_LW_SW) begin
                    use_rs1     = 1'b1;
                    use_rs2     = 1'b1;
                    dec.use_imm = 1'b1;
                    dec.imm     = imm_s;
                    dec.mem_we  = 1'b1;
                end
            end
            `OPC_BRANCH: begin
                if (funct3 == `F3_BEQ || funct3 == `F3_BNE) begin
                    use_rs1       = 1'b1;
                    use_rs2       = 1'b1;
                    dec.imm       = imm_b;
                    dec.branch    = 1'b1;
                    dec.branch_ne = (funct3 == `F3_BNE);
                end
            end
            default: ;
        endcase
        // unused fields read as x0 so they never hit a hazard
        dec.rs1 = use_rs1 ? if_id.insn[19:15] : '0;
        dec.rs2 = use_rs2 ? if_id.insn[24:20] : '0;
        dec.rd  = dec.reg_we ? if_id.insn[11:7] : '0;
    end

    assign rd_addr_0 = dec.rs1;
    assign rd_addr_1 = dec.rs2;

    always_comb begin
        id_ex          = dec;
        id_ex.rs1_data = rd_data_0;
        id_ex.rs2_data = rd_data_1;
    end

endmodule

//--- source/execute.sv
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module execute (
    input  rv_core_pkg::id_ex_t        id_ex,
    input  rv_core_pkg::ex_mem_t       mem_fwd,
    input  logic                       mem_fwd_valid,
    input  logic                       wb_we,
    input  logic [`GPR_ADDR_WIDTH-1:0] wb_addr,
    input  logic [`XLEN-1:0]           wb_data,
    output rv_core_pkg::ex_mem_t       ex_mem,
    output logic                       branch_taken,
    output logic [`XLEN-1:0]           branch_target
);

    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_result;

    // memory stage wins over writeback, writeback over the register file
    function automatic logic [`XLEN-1:0] fwd_operand(
        input logic [`GPR_ADDR_WIDTH-1:0] rs,
        input logic [`XLEN-1:0]           rf_val
    );
        if (rs != '0 && mem_fwd_valid && mem_fwd.reg_we && mem_fwd.rd == rs
                && mem_fwd.wb_sel == rv_core_pkg::WB_ALU) begin
            return mem_fwd.alu_result;
        end else if (rs != '0 && wb_we && wb_addr == rs) begin
            return wb_data;
        end
        return rf_val;
    endfunction

    always_comb begin
        rs1_val = fwd_operand(id_ex.rs1, id_ex.rs1_data);
        rs2_val = fwd_operand(id_ex.rs2, id_ex.rs2_data);
    end

    assign op_b = id_ex.use_imm ? id_ex.imm : rs2_val;

    always_comb begin
        case (id_ex.alu_op)
            rv_core_pkg::ALU_SUB: alu_result = rs1_val - op_b;
            rv_core_pkg::ALU_AND: alu_result = rs1_val & op_b;
            rv_core_pkg::ALU_OR:  alu_result = rs1_val | op_b;
            rv_core_pkg::ALU_XOR: alu_result = rs1_val ^ op_b;
            rv_core_pkg::ALU_SLT: begin
                alu_result = {{(`XLEN-1){1'b0}}, $signed(rs1_val) < $signed(op_b)};
            end
            default: alu_result = rs1_val + op_b;
        endcase
    end

    // beq / bne on the forwarded operands
    assign branch_taken  = id_ex.branch && (id_ex.branch_ne ? (rs1_val != rs2_val)
                                                            : (rs1_val == rs2_val));
    assign branch_target = id_ex.pc + id_ex.imm;

    always_comb begin
        ex_mem.alu_result = alu_result;
        ex_mem.store_data = rs2_val;
        ex_mem.mem_re     = id_ex.mem_re;
        ex_mem.mem_we     = id_ex.mem_we;
        ex_mem.reg_we     = id_ex.reg_we;
        ex_mem.rd         = id_ex.rd;
        ex_mem.wb_sel     = id_ex.wb_sel;
    end

endmodule

//--- source/gpr.sv
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module gpr (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       we,
    input  logic [`GPR_ADDR_WIDTH-1:0] wr_addr,
    input  logic [`XLEN-1:0]           wr_data,
    input  logic [`GPR_ADDR_WIDTH-1:0] rd_addr_0,
    input  logic [`GPR_ADDR_WIDTH-1:0] rd_addr_1,
    output logic [`XLEN-1:0]           rd_data_0,
    output logic [`XLEN-1:0]           rd_data_1
);

    logic [`XLEN-1:0] regs [`GPR_COUNT];

    // x0 stays zero, writes to it are dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `GPR_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    function automatic logic [`XLEN-1:0] read_port(input logic [`GPR_ADDR_WIDTH-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (we && addr == wr_addr) begin
            // write-through for same-cycle writeback
            return wr_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rd_data_0 = read_port(rd_addr_0);
        rd_data_1 = read_port(rd_addr_1);
    end

endmodule

//--- source/pc_ctrl.sv
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module pc_ctrl (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cpu_en,
    input  rv_core_pkg::id_ex_t        id_ex,
    input  logic                       id_ex_valid,
    input  logic [`GPR_ADDR_WIDTH-1:0] rs1_addr,
    input  logic [`GPR_ADDR_WIDTH-1:0] rs2_addr,
    input  logic                       branch_taken,
    input  logic [`XLEN-1:0]           branch_target,
    output logic [`XLEN-1:0]           pc,
    output logic                       if_stall,
    output logic                       id_flush,
    output logic                       if_flush
);

    logic take_branch;
    logic load_use;

    assign take_branch = id_ex_valid && branch_taken;

    // load in execute feeding the instruction in decode
    assign load_use = id_ex_valid && id_ex.mem_re && id_ex.rd != '0
                      && (id_ex.rd == rs1_addr || id_ex.rd == rs2_addr);

    // taken branch cancels the two younger instructions
    assign if_flush = take_branch;
    assign id_flush = take_branch || load_use;
    assign if_stall = load_use && !take_branch;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else if (cpu_en) begin
            if (take_branch) begin
                pc <= branch_target;
            end else if (!if_stall) begin
                pc <= pc + `XLEN'd4;
            end
        end
    end

endmodule

//--- source/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q,
    output logic     valid,
    input  logic     in_valid
);

    always_ff @(posedge clk) begin
        if (en && !stall) begin
            q <= d;
        end
    end

    // a flushed stage turns into a bubble
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (en) begin
            if (flush) begin
                valid <= 1'b0;
            end else if (!stall) begin
                valid <= in_valid;
            end
        end
    end

endmodule

//--- source/pipeline_cpu_top.sv
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module pipeline_cpu_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cpu_en,
    output logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] insn,
    output logic [`XLEN-1:0] data_addr,
    output logic [`XLEN-1:0] data_wdata,
    output logic             data_we,
    output logic             data_re,
    input  logic [`XLEN-1:0] data_rdata
);

    rv_core_pkg::if_id_t        if_id_d, if_id;
    rv_core_pkg::id_ex_t        id_ex_d, id_ex;
    rv_core_pkg::ex_mem_t       ex_mem_d, ex_mem;
    rv_core_pkg::mem_wb_t       mem_wb_d, mem_wb;
    logic                       if_valid, id_valid, ex_valid, mem_valid;
    logic                       if_stall, if_flush, id_flush;
    logic                       branch_taken;
    logic [`XLEN-1:0]           branch_target;
    logic [`GPR_ADDR_WIDTH-1:0] rd_addr_0, rd_addr_1;
    logic [`XLEN-1:0]           rd_data_0, rd_data_1;
    logic                       wb_we;
    logic [`XLEN-1:0]           wb_data;

    pc_ctrl u_pc_ctrl (
        .clk(clk), .rst_n(rst_n), .cpu_en(cpu_en),
        .id_ex(id_ex), .id_ex_valid(id_valid),
        .rs1_addr(rd_addr_0), .rs2_addr(rd_addr_1),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .pc(pc), .if_stall(if_stall), .id_flush(id_flush), .if_flush(if_flush)
    );

    assign if_id_d = '{pc: pc, insn: insn};

    pipe_reg #(.payload_t(rv_core_pkg::if_id_t)) u_if_reg (
        .clk(clk), .rst_n(rst_n), .en(cpu_en), .stall(if_stall), .flush(if_flush),
        .d(if_id_d), .q(if_id), .valid(if_valid), .in_valid(1'b1)
    );

    decoder u_decoder (
        .if_id(if_id), .rd_addr_0(rd_addr_0), .rd_addr_1(rd_addr_1),
        .rd_data_0(rd_data_0), .rd_data_1(rd_data_1), .id_ex(id_ex_d)
    );

    gpr u_gpr (
        .clk(clk), .rst_n(rst_n), .we(wb_we), .wr_addr(mem_wb.rd), .wr_data(wb_data),
        .rd_addr_0(rd_addr_0), .rd_addr_1(rd_addr_1),
        .rd_data_0(rd_data_0), .rd_data_1(rd_data_1)
    );

    pipe_reg #(.payload_t(rv_core_pkg::id_ex_t)) u_id_reg (
        .clk(clk), .rst_n(rst_n), .en(cpu_en), .stall(1'b0), .flush(id_flush),
        .d(id_ex_d), .q(id_ex), .valid(id_valid), .in_valid(if_valid)
    );

    execute u_execute (
        .id_ex(id_ex), .mem_fwd(ex_mem), .mem_fwd_valid(ex_valid),
        .wb_we(wb_we), .wb_addr(mem_wb.rd), .wb_data(wb_data),
        .ex_mem(ex_mem_d), .branch_taken(branch_taken), .branch_target(branch_target)
    );

    pipe_reg #(.payload_t(rv_core_pkg::ex_mem_t)) u_ex_reg (
        .clk(clk), .rst_n(rst_n), .en(cpu_en), .stall(1'b0), .flush(1'b0),
        .d(ex_mem_d), .q(ex_mem), .valid(ex_valid), .in_valid(id_valid)
    );

    // memory stage drives the data port straight from the register
    assign data_addr  = ex_mem.alu_result;
    assign data_wdata = ex_mem.store_data;
    assign data_we    = cpu_en && ex_valid && ex_mem.mem_we;
    assign data_re    = cpu_en && ex_valid && ex_mem.mem_re;

    assign mem_wb_d = '{alu_result: ex_mem.alu_result, reg_we: ex_mem.reg_we,
                        rd: ex_mem.rd, wb_sel: ex_mem.wb_sel};

    pipe_reg #(.payload_t(rv_core_pkg::mem_wb_t)) u_mem_reg (
        .clk(clk), .rst_n(rst_n), .en(cpu_en), .stall(1'b0), .flush(1'b0),
        .d(mem_wb_d), .q(mem_wb), .valid(mem_valid), .in_valid(ex_valid)
    );

    // load data arrives from the sram in the writeback cycle
    assign wb_data = (mem_wb.wb_sel == rv_core_pkg::WB_LOAD) ? data_rdata : mem_wb.alu_result;
    assign wb_we   = cpu_en && mem_valid && mem_wb.reg_we;

endmodule

//--- source/rv_core_consts.svh
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

`define XLEN            32
`define GPR_ADDR_WIDTH  5
`define GPR_COUNT       32
`define RESET_PC        32'h0000_0000

// major opcodes
`define OPC_OP          7'b0110011
`define OPC_OP_IMM      7'b0010011
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011
`define OPC_BRANCH      7'b1100011

`define F3_ADD_SUB      3'b000
`define F3_SLT          3'b010
`define F3_XOR          3'b100
`define F3_OR           3'b110
`define F3_AND          3'b111
`define F3_BEQ          3'b000
`define F3_BNE          3'b001
`define F3_LW_SW        3'b010

`define F7_SUB          7'b0100000

`endif

//--- source/rv_core_pkg.sv
`include "rv_core_consts.svh"

package rv_core_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    typedef enum logic {
        WB_ALU,
        WB_LOAD
    } wb_sel_t;

    typedef struct packed {
        logic [`XLEN-1:0]           pc;
        logic [`XLEN-1:0]           insn;
    } if_id_t;

    typedef struct packed {
        logic [`XLEN-1:0]           pc;
        logic [`GPR_ADDR_WIDTH-1:0] rs1;
        logic [`GPR_ADDR_WIDTH-1:0] rs2;
        logic [`XLEN-1:0]           rs1_data;
        logic [`XLEN-1:0]           rs2_data;
        logic [`XLEN-1:0]           imm;
        logic                       use_imm;
        alu_op_t                    alu_op;
        logic                       branch;
        logic                       branch_ne;
        logic                       mem_re;
        logic                       mem_we;
        logic                       reg_we;
        logic [`GPR_ADDR_WIDTH-1:0] rd;
        wb_sel_t                    wb_sel;
    } id_ex_t;

    typedef struct packed {
        logic [`XLEN-1:0]           alu_result;
        logic [`XLEN-1:0]           store_data;
        logic                       mem_re;
        logic                       mem_we;
        logic                       reg_we;
        logic [`GPR_ADDR_WIDTH-1:0] rd;
        wb_sel_t                    wb_sel;
    } ex_mem_t;

    typedef struct packed {
        logic [`XLEN-1:0]           alu_result;
        logic                       reg_we;
        logic [`GPR_ADDR_WIDTH-1:0] rd;
        wb_sel_t                    wb_sel;
    } mem_wb_t;

endpackage

//--- test/tb_asm.svh
`ifndef TB_ASM_SVH
`define TB_ASM_SVH

`include "rv_core_consts.svh"

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `OPC_OP};
endfunction

function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [11:0] imm,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, `F3_LW_SW, imm[4:0], `OPC_STORE};
endfunction

function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                       input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH};
endfunction

task automatic build_program();
    logic [31:0] word;
    logic [11:0] r1;
    logic [11:0] r2;
    logic [11:0] r3;
    word = next_rand();
    r1 = word[31:20];
    word = next_rand();
    r2 = word[31:20];
    word = next_rand();
    r3 = word[31:20];

    // dependent chain, each result feeds the next op
    add_imm(1, 0, r1);
    add_imm(2, 1, r2);
    alu_reg(`F3_ADD_SUB, 7'd0, 3, 2, 1);
    alu_reg(`F3_ADD_SUB, `F7_SUB, 4, 3, 2);
    alu_reg(`F3_AND, 7'd0, 5, 4, 3);
    alu_reg(`F3_OR, 7'd0, 6, 5, 4);
    alu_reg(`F3_XOR, 7'd0, 7, 6, 1);
    alu_reg(`F3_SLT, 7'd0, 8, 7, 2);
    alu_reg(`F3_SLT, 7'd0, 9, 2, 7);
    store_word(9, 12'h000);
    store_word(3, 12'h004);
    store_word(4, 12'h008);
    store_word(5, 12'h00c);
    store_word(6, 12'h010);
    store_word(7, 12'h014);
    store_word(8, 12'h018);

    // load-use on store data, rs1 and rs2
    load_word(10, 12'h080);
    store_word(10, 12'h040);
    load_word(11, 12'h040);
    alu_reg(`F3_ADD_SUB, 7'd0, 12, 11, 1);
    store_word(12, 12'h044);
    load_word(13, 12'h084);
    alu_reg(`F3_ADD_SUB, 7'd0, 14, 1, 13);
    store_word(14, 12'h048);

    // taken beq / bne skip two, then two fall-through branches
    add_imm(15, 0, 12'd5);
    add_imm(16, 0, 12'd5);
    branch_skip(`F3_BEQ, 15, 16, 2);
    add_imm(15, 0, 12'h7ff);
    store_word(1, 12'h050);
    add_imm(17, 0, 12'd9);
    branch_skip(`F3_BNE, 15, 17, 2);
    add_imm(16, 16, 12'd1);
    add_imm(15, 0, 12'hfff);
    store_word(15, 12'h04c);
    load_word(18, 12'h040);
    branch_skip(`F3_BNE, 18, 10, 2);
    add_imm(18, 16, 12'd3);
    branch_skip(`F3_BEQ, 15, 17, 2);
    alu_reg(`F3_OR, 7'd0, 19, 18, 15);
    store_word(19, 12'h054);

    // x0 must stay zero
    add_imm(0, 0, r3);
    alu_reg(`F3_ADD_SUB, 7'd0, 0, 1, 2);
    store_word(0, 12'h058);
    load_word(0, 12'h040);
    store_word(0, 12'h05c);

    alu_reg(`F3_XOR, 7'd0, 20, 12, 10);
    store_word(20, 12'h060);
    load_word(21, 12'h060);
    alu_reg(`F3_ADD_SUB, `F7_SUB, 22, 21, 1);
    alu_reg(`F3_SLT, 7'd0, 23, 22, 21);
    store_word(22, 12'h064);
    store_word(23, 12'h068);

    // addi x0 with the word index as immediate
    for (int i = insn_count; i < 256; i++) begin
        imem[8'(i)] = i_type(`OPC_OP_IMM, 12'(i), 5'd0, `F3_ADD_SUB, 5'd0);
    end
endtask

`endif

//--- test/tb_pipeline_cpu_top.sv
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module tb_pipeline_cpu_top;

    localparam int FREEZE_AFTER  = 12;
    localparam int FREEZE_CYCLES = 6;

    logic        clk;
    logic        rst_n;
    logic        cpu_en;
    logic [31:0] pc;
    logic [31:0] insn;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic        data_we;
    logic        data_re;
    logic [31:0] data_rdata = '0;
    logic [31:0] rdata_q = '0;

    logic [31:0] imem [256];
    logic [31:0] dmem [64];
    logic [31:0] shadow_dm [64];
    logic [31:0] xr [32];
    logic [31:0] exp_addr_q [$];
    logic [31:0] exp_data_q [$];
    logic [31:0] rng_state;
    int          insn_count;
    int          skip_left;
    int          total_stores;
    int          stores_seen;

    pipeline_cpu_top u_pipeline_cpu_top (
        .clk(clk), .rst_n(rst_n), .cpu_en(cpu_en), .pc(pc), .insn(insn),
        .data_addr(data_addr), .data_wdata(data_wdata), .data_we(data_we),
        .data_re(data_re), .data_rdata(data_rdata)
    );

    `include "tb_asm.svh"

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    assign insn = imem[pc[9:2]];

    // synchronous sram returns read data in the writeback cycle
    always @(posedge clk) begin
        if (data_re) rdata_q <= dmem[data_addr[7:2]];
        if (data_we) dmem[data_addr[7:2]] = data_wdata;
    end

    always @(negedge clk) data_rdata <= rdata_q;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        fail_run($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, want));
    endtask

    // reference model places the word and retires it unless a taken branch skips it
    task automatic place_insn(input logic [31:0] word, output bit live);
        live = (skip_left == 0);
        if (!live) skip_left--;
        imem[8'(insn_count)] = word;
        insn_count++;
    endtask

    task automatic alu_reg(input logic [2:0] f3, input logic [6:0] f7, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [4:0] rs2);
        bit          live;
        logic [31:0] r;
        place_insn(r_type(f7, rs2, rs1, f3, rd), live);
        case (f3)
            `F3_SLT: r = ($signed(xr[rs1]) < $signed(xr[rs2])) ? 32'd1 : 32'd0;
            `F3_XOR: r = xr[rs1] ^ xr[rs2];
            `F3_OR:  r = xr[rs1] | xr[rs2];
            `F3_AND: r = xr[rs1] & xr[rs2];
            default: r = (f7 == `F7_SUB) ? xr[rs1] - xr[rs2] : xr[rs1] + xr[rs2];
        endcase
        if (live && rd != 5'd0) xr[rd] = r;
    endtask

    task automatic add_imm(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        bit live;
        place_insn(i_type(`OPC_OP_IMM, imm, rs1, `F3_ADD_SUB, rd), live);
        if (live && rd != 5'd0) xr[rd] = xr[rs1] + {{20{imm[11]}}, imm};
    endtask

    task automatic load_word(input logic [4:0] rd, input logic [11:0] imm);
        bit live;
        place_insn(i_type(`OPC_LOAD, imm, 5'd0, `F3_LW_SW, rd), live);
        if (live && rd != 5'd0) xr[rd] = shadow_dm[imm[7:2]];
    endtask

    task automatic store_word(input logic [4:0] rs2, input logic [11:0] imm);
        bit live;
        place_insn(s_type(imm, rs2, 5'd0), live);
        if (live) begin
            shadow_dm[imm[7:2]] = xr[rs2];
            exp_addr_q.push_back({20'd0, imm});
            exp_data_q.push_back(xr[rs2]);
            total_stores++;
        end
    endtask

    task automatic branch_skip(input logic [2:0] f3, input logic [4:0] rs1,
                               input logic [4:0] rs2, input int skip);
        bit live;
        bit taken;
        place_insn(b_type(f3, rs1, rs2, 13'((skip + 1) * 4)), live);
        taken = (f3 == `F3_BNE) ? (xr[rs1] != xr[rs2]) : (xr[rs1] == xr[rs2]);
        if (live && taken) skip_left = skip;
    endtask

    always @(posedge clk) begin
        if (rst_n && data_we) begin
            assert (exp_data_q.size() > 0)
                else fail_run("a store was issued when no store was expected");
            assert (data_addr == exp_addr_q[0])
                else report_mismatch("data_addr", data_addr, exp_addr_q[0]);
            assert (data_wdata == exp_data_q[0])
                else report_mismatch("data_wdata", data_wdata, exp_data_q[0]);
            void'(exp_addr_q.pop_front());
            void'(exp_data_q.pop_front());
            stores_seen++;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) cpu_en || (!data_we && !data_re))
        else fail_run("data port strobe seen while the core was frozen");

    task automatic check_idle();
        assert (pc == `RESET_PC) else report_mismatch("pc", pc, `RESET_PC);
        assert (!data_we) else report_mismatch("data_we", {31'd0, data_we}, 32'd0);
        assert (!data_re) else report_mismatch("data_re", {31'd0, data_re}, 32'd0);
    endtask

    task automatic wait_stores(input int target, input int limit);
        int n;
        n = 0;
        while (stores_seen < target) begin
            @(negedge clk);
            n++;
            if (n > limit) fail_run("timed out waiting for the expected stores");
        end
    endtask

    task automatic freeze_core(input int cycles);
        logic [31:0] held_pc;
        cpu_en = 1'b0;
        held_pc = pc;
        repeat (cycles) begin
            @(negedge clk);
            assert (pc == held_pc) else report_mismatch("pc", pc, held_pc);
            assert (!data_we) else report_mismatch("data_we", {31'd0, data_we}, 32'd0);
        end
        cpu_en = 1'b1;
    endtask

    initial begin
        rng_state = 32'd14649;
        rst_n = 1'b0;
        cpu_en = 1'b1;
        insn_count = 0;
        skip_left = 0;
        total_stores = 0;
        stores_seen = 0;
        xr = '{default: '0};
        for (int i = 0; i < 64; i++) begin
            dmem[6'(i)] = next_rand();
            shadow_dm[6'(i)] = dmem[6'(i)];
        end
        build_program();

        repeat (8) begin
            @(negedge clk);
            check_idle();
        end
        rst_n = 1'b1;

        // first enabled edge fetches from the reset pc
        @(negedge clk);
        assert (pc == `RESET_PC + 32'd4)
            else report_mismatch("pc", pc, `RESET_PC + 32'd4);
        assert (!data_we) else report_mismatch("data_we", {31'd0, data_we}, 32'd0);
        assert (!data_re) else report_mismatch("data_re", {31'd0, data_re}, 32'd0);

        wait_stores(FREEZE_AFTER, 200);
        freeze_core(FREEZE_CYCLES);
        wait_stores(total_stores, 400);
        // quiet period to catch stray stores
        repeat (10) @(negedge clk);

        if (exp_data_q.size() == 0 && stores_seen == total_stores) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            fail_run("expected stores were left unmatched at the end of the run");
        end
    end

endmodule
